//--- cache_data_banks.sv
// Line storage of the four ways; all ways are read each cycle and the hit way is picked afterwards
`timescale 1ns/1ps
`default_nettype none

module cache_data_banks
(
	input wire clk,
	input wire [l1_cache_pkg::SET_INDEX_WIDTH - 1:0] read_set_i,
	input wire write_i,
	input wire [l1_cache_pkg::SET_INDEX_WIDTH - 1:0] write_set_i,
	input wire [l1_cache_pkg::WAY_INDEX_WIDTH - 1:0] write_way_i,
	input wire [l1_cache_pkg::LINE_BITS - 1:0] write_data_i,
	input wire [l1_cache_pkg::WAY_INDEX_WIDTH - 1:0] hit_way_i,
	output logic [l1_cache_pkg::LINE_BITS - 1:0] data_o
);
	import l1_cache_pkg::*;

	logic [LINE_BITS - 1:0] way_read_data [NUM_WAYS];

	for (genvar w = 0; w < NUM_WAYS; w++)
	begin : g_bank
		logic [LINE_BITS - 1:0] lines [NUM_SETS];
		logic [LINE_BITS - 1:0] read_data;

		always_ff @(posedge clk)
		begin
			if (write_i && write_way_i == WAY_INDEX_WIDTH'(w))
				lines[write_set_i] <= write_data_i;
			read_data <= lines[read_set_i];
		end

		assign way_read_data[w] = read_data;
	end

	// The tag compare settles in the result cycle, so the way mux sits after the banks
	assign data_o = way_read_data[hit_way_i];

endmodule

`default_nettype wire

//--- cache_lru.sv
// Tree pseudo-LRU state per set; names the victim way and records each touched way as MRU
`timescale 1ns/1ps
`default_nettype none

module cache_lru
(
	input wire clk,
	input wire rst_i,
	input wire [l1_cache_pkg::SET_INDEX_WIDTH - 1:0] set_i,
	input wire update_i,
	input wire [l1_cache_pkg::WAY_INDEX_WIDTH - 1:0] new_mru_way_i,
	output logic [l1_cache_pkg::WAY_INDEX_WIDTH - 1:0] lru_way_o
);
	import l1_cache_pkg::*;

	// Bit 0 picks the pair (0 = ways 0/1, 1 = ways 2/3)
	// Bit 1 picks inside the low pair and bit 2 inside the high pair
	logic [2:0] tree [NUM_SETS];
	logic [2:0] current;
	logic [2:0] updated;

	assign current = tree[set_i];

	always_comb
	begin
		if (current[0])
			lru_way_o = {1'b1, current[2]};
		else
			lru_way_o = {1'b0, current[1]};
	end

	// Every node on the path to the touched way is turned to point away from it
	always_comb
	begin
		updated = current;
		updated[0] = ~new_mru_way_i[1];
		if (new_mru_way_i[1])
			updated[2] = ~new_mru_way_i[0];
		else
			updated[1] = ~new_mru_way_i[0];
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int s = 0; s < NUM_SETS; s++)
				tree[s] <= 3'b000;
		end
		else if (update_i)
		begin
			tree[set_i] <= updated;
		end
	end

endmodule

`default_nettype wire

//--- cache_tag_mem.sv
// Tag and valid arrays of the four ways; looked up on each access and written on a line fill
`timescale 1ns/1ps
`default_nettype none

module cache_tag_mem
(
	input wire clk,
	input wire rst_i,
	input wire [31:0] address_i,
	input wire access_i,
	input wire update_i,
	input wire [l1_cache_pkg::SET_INDEX_WIDTH - 1:0] update_set_i,
	input wire [l1_cache_pkg::WAY_INDEX_WIDTH - 1:0] update_way_i,
	input wire [l1_cache_pkg::TAG_WIDTH - 1:0] update_tag_i,
	output logic [l1_cache_pkg::WAY_INDEX_WIDTH - 1:0] hit_way_o,
	output logic cache_hit_o
);
	import l1_cache_pkg::*;

	logic [SET_INDEX_WIDTH - 1:0] requested_set;
	logic [TAG_WIDTH - 1:0] tag_latched;
	logic access_latched;
	logic [NUM_WAYS - 1:0] way_hit;

	assign requested_set = address_i[31 - TAG_WIDTH -: SET_INDEX_WIDTH];

	always_ff @(posedge clk)
	begin
		if (rst_i)
			access_latched <= 1'b0;
		else
			access_latched <= access_i;
	end

	always_ff @(posedge clk)
	begin
		tag_latched <= address_i[31 -: TAG_WIDTH];
	end

	for (genvar w = 0; w < NUM_WAYS; w++)
	begin : g_way
		logic [TAG_WIDTH - 1:0] tags [NUM_SETS];
		logic [NUM_SETS - 1:0] valid;
		logic [TAG_WIDTH - 1:0] tag_read;
		logic valid_read;
		logic fill_this_way;

		assign fill_this_way = update_i && update_way_i == WAY_INDEX_WIDTH'(w);

		// A read in the fill cycle still returns the old tag
		always_ff @(posedge clk)
		begin
			if (fill_this_way)
				tags[update_set_i] <= update_tag_i;
			tag_read <= tags[requested_set];
		end

		always_ff @(posedge clk)
		begin
			if (rst_i)
			begin
				valid <= '0;
				valid_read <= 1'b0;
			end
			else
			begin
				if (fill_this_way)
					valid[update_set_i] <= 1'b1;
				valid_read <= valid[requested_set];
			end
		end

		assign way_hit[w] = valid_read && tag_read == tag_latched;
	end

	// At most one way can hold a given tag, so a plain encode is enough
	always_comb
	begin
		hit_way_o = '0;
		for (int w = 0; w < NUM_WAYS; w++)
			if (way_hit[w])
				hit_way_o = WAY_INDEX_WIDTH'(w);
	end

	assign cache_hit_o = access_latched && |way_hit;

endmodule

`default_nettype wire

//--- l1_cache.f
l1_cache_pkg.sv
cache_tag_mem.sv
cache_data_banks.sv
cache_lru.sv
load_miss_queue.sv
l1_cache.sv
tb_clock_gen.sv
tb_l1_cache_asserts.sv
tb_l1_cache.sv

//--- l1_cache.sv
// Top of the read-only L1 cache; the core accesses it and it exchanges line requests and fills with L2
`timescale 1ns/1ps
`default_nettype none

module l1_cache
(
	input wire clk,
	input wire rst_i,
	input wire [31:0] address_i,
	input wire access_i,
	input wire [1:0] strand_i,
	input wire pci_credit_i,
	input wire cpi_valid_i,
	input wire [1:0] cpi_strand_i,
	input wire [l1_cache_pkg::WAY_INDEX_WIDTH - 1:0] cpi_way_i,
	input wire [l1_cache_pkg::LINE_BITS - 1:0] cpi_data_i,
	output logic [l1_cache_pkg::LINE_BITS - 1:0] data_o,
	output logic cache_hit_o,
	output logic load_collision_o,
	output logic [l1_cache_pkg::NUM_STRANDS - 1:0] load_complete_strands_o,
	output logic pci_valid_o,
	output logic [1:0] pci_strand_o,
	output logic [l1_cache_pkg::WAY_INDEX_WIDTH - 1:0] pci_way_o,
	output logic [l1_cache_pkg::LINE_ADDR_WIDTH - 1:0] pci_address_o
);
	import l1_cache_pkg::*;

	logic [SET_INDEX_WIDTH - 1:0] requested_set;
	logic [TAG_WIDTH - 1:0] requested_tag;
	logic access_latched;
	logic [1:0] strand_latched;
	logic [SET_INDEX_WIDTH - 1:0] request_set_latched;
	logic [TAG_WIDTH - 1:0] request_tag_latched;
	logic [WAY_INDEX_WIDTH - 1:0] hit_way;
	logic [WAY_INDEX_WIDTH - 1:0] lru_way;
	logic [WAY_INDEX_WIDTH - 1:0] new_mru_way;
	logic [SET_INDEX_WIDTH - 1:0] lru_set;
	logic access_update;
	logic queue_miss;
	logic load_collision_early;
	logic load_collision_late;
	logic [SET_INDEX_WIDTH - 1:0] load_complete_set;
	logic [TAG_WIDTH - 1:0] load_complete_tag;
	logic [WAY_INDEX_WIDTH - 1:0] load_complete_way;

	assign requested_set = address_i[31 - TAG_WIDTH -: SET_INDEX_WIDTH];
	assign requested_tag = address_i[31 -: TAG_WIDTH];

	// A fill landing while the access reads the arrays leaves the line absent from the tags.
	// Re-requesting it would put the same line in two ways, so the core retries instead
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			access_latched <= 1'b0;
			load_collision_early <= 1'b0;
		end
		else
		begin
			access_latched <= access_i;
			load_collision_early <= access_i && cpi_valid_i
				&& load_complete_set == requested_set
				&& load_complete_tag == requested_tag;
		end
	end

	always_ff @(posedge clk)
	begin
		strand_latched <= strand_i;
		request_set_latched <= requested_set;
		request_tag_latched <= requested_tag;
	end

	assign load_collision_late = access_latched && cpi_valid_i
		&& load_complete_set == request_set_latched
		&& load_complete_tag == request_tag_latched;

	assign load_collision_o = load_collision_early || load_collision_late;
	assign queue_miss = access_latched && !cache_hit_o && !load_collision_o;

	// The victim becomes MRU at miss time so another miss in the set does not pick it too.
	// Without an access update, a fill refreshes the way it wrote
	assign access_update = cache_hit_o || queue_miss;
	assign lru_set = access_update ? request_set_latched : load_complete_set;

	always_comb
	begin
		if (!access_update)
			new_mru_way = load_complete_way;
		else if (cache_hit_o)
			new_mru_way = hit_way;
		else
			new_mru_way = lru_way;
	end

	// The fill strobe for all arrays is the L2 fill itself, which is never stalled
	cache_tag_mem tag_mem (
		.clk(clk),
		.rst_i(rst_i),
		.address_i(address_i),
		.access_i(access_i),
		.update_i(cpi_valid_i),
		.update_set_i(load_complete_set),
		.update_way_i(load_complete_way),
		.update_tag_i(load_complete_tag),
		.hit_way_o(hit_way),
		.cache_hit_o(cache_hit_o)
	);

	cache_data_banks data_banks (
		.clk(clk),
		.read_set_i(requested_set),
		.write_i(cpi_valid_i),
		.write_set_i(load_complete_set),
		.write_way_i(load_complete_way),
		.write_data_i(cpi_data_i),
		.hit_way_i(hit_way),
		.data_o(data_o)
	);

	cache_lru lru (
		.clk(clk),
		.rst_i(rst_i),
		.set_i(lru_set),
		.update_i(access_update || cpi_valid_i),
		.new_mru_way_i(new_mru_way),
		.lru_way_o(lru_way)
	);

	load_miss_queue lmq (
		.clk(clk),
		.rst_i(rst_i),
		.request_i(queue_miss),
		.tag_i(request_tag_latched),
		.set_i(request_set_latched),
		.victim_way_i(lru_way),
		.strand_i(strand_latched),
		.pci_credit_i(pci_credit_i),
		.cpi_valid_i(cpi_valid_i),
		.cpi_strand_i(cpi_strand_i),
		.cpi_way_i(cpi_way_i),
		.load_complete_strands_o(load_complete_strands_o),
		.load_complete_set_o(load_complete_set),
		.load_complete_tag_o(load_complete_tag),
		.load_complete_way_o(load_complete_way),
		.pci_valid_o(pci_valid_o),
		.pci_strand_o(pci_strand_o),
		.pci_way_o(pci_way_o),
		.pci_address_o(pci_address_o)
	);

endmodule

`default_nettype wire

//--- l1_cache_input.txt
// Columns: expected result (0 miss, 1 hit, 2 collision), strand, byte address
// A line starting with f ends the list
0_0_00001000
1_0_00001000
1_0_00001024
0_0_000008C0
0_0_000010C0
1_0_000008C0
0_0_000018C0
1_0_000008C0
0_0_000020C0
1_0_000008C0
0_0_000028C0
1_0_000008C0
1_0_000020C0
0_0_000010C0
0_0_00100100
0_1_00200140
0_2_00300180
0_3_004001C0
1_0_00100100
1_1_00200140
1_2_00300180
1_3_004001C0
0_0_00500200
2_1_00500200
1_1_00500200
f_0_00000000

//--- l1_cache_pkg.sv
// Cache geometry, L2 credit count and miss entry states, imported by all L1 cache blocks
`default_nettype none

package l1_cache_pkg;

	// 4 ways, 32 sets, 64-byte lines over a 32-bit address
	localparam int TAG_WIDTH = 21;
	localparam int SET_INDEX_WIDTH = 5;
	localparam int WAY_INDEX_WIDTH = 2;
	localparam int NUM_SETS = 32;
	localparam int NUM_WAYS = 4;
	localparam int NUM_STRANDS = 4;
	localparam int LINE_BITS = 512;

	// A line address is the tag followed by the set index
	localparam int LINE_ADDR_WIDTH = TAG_WIDTH + SET_INDEX_WIDTH;

	// Request credits the L2 grants to the cache out of reset
	localparam int L2_CREDITS = 2;
	localparam int CREDIT_WIDTH = $clog2(L2_CREDITS + 1);

	// Life of one per-strand miss entry
	typedef enum logic [1:0]
	{
		MISS_IDLE,
		// Waiting for a credit before the request can go out
		MISS_PENDING,
		// Request sent, waiting for the line to come back
		MISS_WAIT_FILL
	} miss_state_t;

endpackage

`default_nettype wire

//--- load_miss_queue.sv
// Per-strand load miss entries; sends line requests to the L2 under credit control and retires fills
`timescale 1ns/1ps
`default_nettype none

module load_miss_queue
(
	input wire clk,
	input wire rst_i,
	input wire request_i,
	input wire [l1_cache_pkg::TAG_WIDTH - 1:0] tag_i,
	input wire [l1_cache_pkg::SET_INDEX_WIDTH - 1:0] set_i,
	input wire [l1_cache_pkg::WAY_INDEX_WIDTH - 1:0] victim_way_i,
	input wire [1:0] strand_i,
	input wire pci_credit_i,
	input wire cpi_valid_i,
	input wire [1:0] cpi_strand_i,
	input wire [l1_cache_pkg::WAY_INDEX_WIDTH - 1:0] cpi_way_i,
	output logic [l1_cache_pkg::NUM_STRANDS - 1:0] load_complete_strands_o,
	output logic [l1_cache_pkg::SET_INDEX_WIDTH - 1:0] load_complete_set_o,
	output logic [l1_cache_pkg::TAG_WIDTH - 1:0] load_complete_tag_o,
	output logic [l1_cache_pkg::WAY_INDEX_WIDTH - 1:0] load_complete_way_o,
	output logic pci_valid_o,
	output logic [1:0] pci_strand_o,
	output logic [l1_cache_pkg::WAY_INDEX_WIDTH - 1:0] pci_way_o,
	output logic [l1_cache_pkg::LINE_ADDR_WIDTH - 1:0] pci_address_o
);
	import l1_cache_pkg::*;

	miss_state_t entry_state [NUM_STRANDS];
	logic [TAG_WIDTH - 1:0] entry_tag [NUM_STRANDS];
	logic [SET_INDEX_WIDTH - 1:0] entry_set [NUM_STRANDS];
	logic [WAY_INDEX_WIDTH - 1:0] entry_way [NUM_STRANDS];
	logic [CREDIT_WIDTH - 1:0] credit_count;
	logic issue_found;
	logic [1:0] issue_strand;
	logic issue;

	// Lowest numbered pending strand goes first
	always_comb
	begin
		issue_found = 1'b0;
		issue_strand = 2'd0;
		for (int s = NUM_STRANDS - 1; s >= 0; s--)
		begin
			if (entry_state[s] == MISS_PENDING)
			begin
				issue_found = 1'b1;
				issue_strand = 2'(s);
			end
		end
	end

	assign issue = issue_found && credit_count != '0;

	assign pci_valid_o = issue;
	assign pci_strand_o = issue_strand;
	assign pci_way_o = entry_way[issue_strand];
	assign pci_address_o = {entry_tag[issue_strand], entry_set[issue_strand]};

	// The fill target is known in the fill cycle itself, so the arrays are written at that edge
	assign load_complete_set_o = entry_set[cpi_strand_i];
	assign load_complete_tag_o = entry_tag[cpi_strand_i];
	assign load_complete_way_o = cpi_way_i;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
				entry_state[s] <= MISS_IDLE;
			credit_count <= CREDIT_WIDTH'(L2_CREDITS);
			load_complete_strands_o <= '0;
		end
		else
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				if (cpi_valid_i && cpi_strand_i == 2'(s))
					entry_state[s] <= MISS_IDLE;
				else if (issue && issue_strand == 2'(s))
					entry_state[s] <= MISS_WAIT_FILL;
				else if (request_i && strand_i == 2'(s))
					entry_state[s] <= MISS_PENDING;
			end

			// A credit coming back in the issue cycle cancels the one just spent
			if (issue && !pci_credit_i)
				credit_count <= credit_count - 1'b1;
			else if (pci_credit_i && !issue)
				credit_count <= credit_count + 1'b1;

			load_complete_strands_o <= '0;
			if (cpi_valid_i)
				load_complete_strands_o[cpi_strand_i] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (request_i)
		begin
			entry_tag[strand_i] <= tag_i;
			entry_set[strand_i] <= set_i;
			entry_way[strand_i] <= victim_way_i;
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the L1 cache testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_l1_cache -f l1_cache.f -o sim_l1_cache &&
./obj_dir/sim_l1_cache | tee /dev/stderr | grep -q "Testbench passed" &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }

//--- tb_clock_gen.sv
// Testbench clock and reset source; a 20 ns clock with reset held for the first four cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
	output logic clk_o,
	output logic rst_o
);

	initial
	begin
		clk_o = 1'b0;
		rst_o = 1'b1;
		repeat (4) @(posedge clk_o);
		// Released just after the edge like every other testbench input
		#1 rst_o = 1'b0;
	end

	always #10 clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- tb_l1_cache.sv
// Testbench for the L1 cache; replays l1_cache_input.txt against a behavioral L2 with random latency
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache;
	import l1_cache_pkg::*;

	localparam int MAX_ENTRIES = 64;

	wire clk;
	wire rst;
	logic [31:0] address;
	logic access;
	logic [1:0] strand;
	logic pci_credit;
	logic cpi_valid;
	logic [1:0] cpi_strand;
	logic [WAY_INDEX_WIDTH - 1:0] cpi_way;
	logic [LINE_BITS - 1:0] cpi_data;
	wire [LINE_BITS - 1:0] data;
	wire cache_hit;
	wire load_collision;
	wire [NUM_STRANDS - 1:0] load_complete_strands;
	wire pci_valid;
	wire [1:0] pci_strand;
	wire [WAY_INDEX_WIDTH - 1:0] pci_way;
	wire [LINE_ADDR_WIDTH - 1:0] pci_address;

	logic [39:0] entries [MAX_ENTRIES];
	int num_entries;
	int cycle_limit = 0;
	int cycle_count = 0;
	int error_count = 0;
	int monitor_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int requests_seen = 0;
	int misses_expected = 0;
	int outstanding = 0;
	int miss_count [NUM_STRANDS];
	int done_count [NUM_STRANDS];
	logic [LINE_ADDR_WIDTH - 1:0] pending_line [NUM_STRANDS];
	logic [NUM_STRANDS - 1:0] complete_expected = '0;
	logic [31:0] lcg_state = 32'h0164cbd4;

	// Requests waiting in the L2 model
	int fill_due [$];
	logic [1:0] fill_strand_q [$];
	logic [WAY_INDEX_WIDTH - 1:0] fill_way_q [$];
	logic [LINE_ADDR_WIDTH - 1:0] fill_line_q [$];
	logic fill_go = 1'b0;
	logic [1:0] fill_go_strand;
	logic [WAY_INDEX_WIDTH - 1:0] fill_go_way;
	logic [LINE_ADDR_WIDTH - 1:0] fill_go_line;

	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Word k of a line holds the line address shifted left by four, plus k
	function automatic logic [LINE_BITS - 1:0] line_pattern(
		input logic [LINE_ADDR_WIDTH - 1:0] line);
		logic [LINE_BITS - 1:0] result;
		result = '0;
		for (int k = 0; k < 16; k++)
			result[k * 32 +: 32] = {2'b00, line, 4'b0000} + 32'(k);
		return result;
	endfunction

	tb_clock_gen clock_gen (
		.clk_o(clk),
		.rst_o(rst)
	);

	l1_cache uut (
		.clk(clk),
		.rst_i(rst),
		.address_i(address),
		.access_i(access),
		.strand_i(strand),
		.pci_credit_i(pci_credit),
		.cpi_valid_i(cpi_valid),
		.cpi_strand_i(cpi_strand),
		.cpi_way_i(cpi_way),
		.cpi_data_i(cpi_data),
		.data_o(data),
		.cache_hit_o(cache_hit),
		.load_collision_o(load_collision),
		.load_complete_strands_o(load_complete_strands),
		.pci_valid_o(pci_valid),
		.pci_strand_o(pci_strand),
		.pci_way_o(pci_way),
		.pci_address_o(pci_address)
	);

	bind load_miss_queue tb_l1_cache_asserts credit_asserts (
		.clk(clk),
		.rst_i(rst_i),
		.pci_valid_i(pci_valid_o),
		.pci_credit_i(pci_credit_i),
		.credit_count_i(credit_count),
		.cpi_valid_i(cpi_valid_i),
		.fill_strand_waiting_i(entry_state[cpi_strand_i] == l1_cache_pkg::MISS_WAIT_FILL)
	);

	// Cycle count, run limit and the fill side of the L2 model
	always @(posedge clk)
	begin : l2_fill
		int pick;
		pick = 0;
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
		begin
			$display("Timeout: run passed %0d cycles without finishing", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
		else
		begin
			fill_go = 1'b0;
			for (int i = 0; i < fill_due.size(); i++)
			begin
				if (!fill_go && fill_due[i] <= cycle_count)
				begin
					fill_go = 1'b1;
					pick = i;
				end
			end
			if (fill_go)
			begin
				fill_go_strand = fill_strand_q[pick];
				fill_go_way = fill_way_q[pick];
				fill_go_line = fill_line_q[pick];
				fill_due.delete(pick);
				fill_strand_q.delete(pick);
				fill_way_q.delete(pick);
				fill_line_q.delete(pick);
			end
			#1;
			// The credit goes back together with the line
			cpi_valid = fill_go;
			pci_credit = fill_go;
			if (fill_go)
			begin
				cpi_strand = fill_go_strand;
				cpi_way = fill_go_way;
				cpi_data = line_pattern(fill_go_line);
			end
		end
	end

	// Request side of the L2 model and completion monitor
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (pci_credit)
				outstanding--;
			if (pci_valid)
			begin
				requests_seen++;
				outstanding++;
				if (outstanding > L2_CREDITS)
				begin
					$display("Error at %0t: %0d requests outstanding", $time, outstanding);
					monitor_errors++;
				end
				if (miss_count[pci_strand] == done_count[pci_strand])
				begin
					$display("Error at %0t: request for strand %0d without a miss",
						$time, pci_strand);
					monitor_errors++;
				end
				else if (pci_address !== pending_line[pci_strand])
				begin
					$display("** Error at %0t: pci_address_o = %h, expected %h",
						$time, pci_address, pending_line[pci_strand]);
					monitor_errors++;
				end
				lcg_state = next_random(lcg_state);
				fill_due.push_back(cycle_count + 2 + int'(lcg_state[18:16]));
				fill_strand_q.push_back(pci_strand);
				fill_way_q.push_back(pci_way);
				fill_line_q.push_back(pci_address);
			end
			// A fill in one cycle shows as its strand's completion bit in the next
			if (load_complete_strands !== complete_expected)
			begin
				$display("** Error at %0t: load_complete_strands_o = %b, expected %b",
					$time, load_complete_strands, complete_expected);
				monitor_errors++;
			end
			complete_expected = '0;
			if (cpi_valid)
				complete_expected[cpi_strand] = 1'b1;
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				if (load_complete_strands[s])
				begin
					if (done_count[s] >= miss_count[s])
					begin
						$display("Error at %0t: strand %0d completed with no miss pending",
							$time, s);
						monitor_errors++;
					end
					else
						done_count[s]++;
				end
			end
		end
	end

	task automatic run_access(input int idx);
		logic [3:0] kind;
		logic [1:0] s;
		logic [31:0] addr;
		logic exp_hit;
		logic exp_collision;
		int errors_before;
		kind = entries[idx][39:36];
		s = entries[idx][33:32];
		addr = entries[idx][31:0];
		exp_hit = kind == 4'd1;
		exp_collision = kind == 4'd2;
		errors_before = error_count + monitor_errors;
		// A strand may not access again until its miss has been filled
		while (miss_count[s] != done_count[s])
			@(posedge clk);
		@(posedge clk);
		#1;
		// A collision access lands in the very cycle its line is being filled
		if (exp_collision)
		begin
			while (!(fill_go && fill_go_line == addr[31:6]))
			begin
				@(posedge clk);
				#1;
			end
		end
		access = 1'b1;
		strand = s;
		address = addr;
		@(posedge clk);
		#1;
		access = 1'b0;
		@(negedge clk);
		if (cache_hit !== exp_hit)
		begin
			$display("** Error at %0t: cache_hit_o = %b, expected %b", $time, cache_hit, exp_hit);
			error_count++;
		end
		if (load_collision !== exp_collision)
		begin
			$display("** Error at %0t: load_collision_o = %b, expected %b",
				$time, load_collision, exp_collision);
			error_count++;
		end
		if (exp_hit && data !== line_pattern(addr[31:6]))
		begin
			$display("** Error at %0t: data_o = %h, expected %h",
				$time, data, line_pattern(addr[31:6]));
			error_count++;
		end
		if (kind == 4'd0)
		begin
			pending_line[s] = addr[31:6];
			miss_count[s]++;
			misses_expected++;
		end
		if (error_count + monitor_errors == errors_before)
			tests_passed++;
		else
			tests_failed++;
		$display("Access %0d: strand %0d address %h kind %0d %s", idx, s, addr, kind,
			(error_count + monitor_errors == errors_before) ? "ok" : "FAILED");
	endtask

	initial
	begin
		address = '0;
		access = 1'b0;
		strand = '0;
		pci_credit = 1'b0;
		cpi_valid = 1'b0;
		cpi_strand = '0;
		cpi_way = '0;
		cpi_data = '0;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			miss_count[s] = 0;
			done_count[s] = 0;
			pending_line[s] = '0;
		end
		for (int i = 0; i < MAX_ENTRIES; i++)
			entries[i] = '1;
		$readmemh("l1_cache_input.txt", entries);
		num_entries = 0;
		while (num_entries < MAX_ENTRIES && entries[num_entries][39:36] != 4'hf)
			num_entries++;
		cycle_limit = 40 * num_entries + 200;

		@(posedge clk);
		while (rst)
			@(posedge clk);
		@(negedge clk);
		if (pci_valid !== 1'b0)
		begin
			$display("** Error at %0t: pci_valid_o = %b, expected 0", $time, pci_valid);
			error_count++;
		end
		if (load_complete_strands !== '0)
		begin
			$display("** Error at %0t: load_complete_strands_o = %b, expected 0000",
				$time, load_complete_strands);
			error_count++;
		end
		if (cache_hit !== 1'b0)
		begin
			$display("** Error at %0t: cache_hit_o = %b, expected 0", $time, cache_hit);
			error_count++;
		end
		if (load_collision !== 1'b0)
		begin
			$display("** Error at %0t: load_collision_o = %b, expected 0",
				$time, load_collision);
			error_count++;
		end
		if (error_count == 0)
			tests_passed++;
		else
			tests_failed++;
		$display("Reset check %s", (error_count == 0) ? "ok" : "FAILED");

		for (int i = 0; i < num_entries; i++)
			run_access(i);

		// Let every outstanding miss finish
		for (int s = 0; s < NUM_STRANDS; s++)
			while (miss_count[s] != done_count[s])
				@(posedge clk);
		repeat (2) @(posedge clk);
		if (requests_seen != misses_expected)
		begin
			$display("Error: %0d L2 requests seen, %0d misses expected",
				requests_seen, misses_expected);
			error_count++;
		end

		$display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
			error_count + monitor_errors);
		if (error_count + monitor_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_l1_cache_asserts.sv
// Credit and fill rules of the load miss queue, bound into load_miss_queue by the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache_asserts
(
	input wire clk,
	input wire rst_i,
	input wire pci_valid_i,
	input wire pci_credit_i,
	input wire [l1_cache_pkg::CREDIT_WIDTH - 1:0] credit_count_i,
	input wire cpi_valid_i,
	input wire fill_strand_waiting_i
);
	import l1_cache_pkg::*;

	int credits_left;

	// Credits left as counted from the request and credit pulses on the L2 side
	always_ff @(posedge clk)
	begin
		if (rst_i)
			credits_left <= L2_CREDITS;
		else
			credits_left <= credits_left - int'(pci_valid_i) + int'(pci_credit_i);
	end

	// A request needs a credit to spend
	request_has_credit: assert property (@(posedge clk) disable iff (rst_i)
		pci_valid_i |-> credits_left > 0)
		else $error("L2 request issued with no credit left");

	credit_in_range: assert property (@(posedge clk) disable iff (rst_i)
		int'(credit_count_i) <= L2_CREDITS)
		else $error("Credit count above the number granted by the L2");

	// Only a strand whose request went out may receive a line
	fill_matches_entry: assert property (@(posedge clk) disable iff (rst_i)
		cpi_valid_i |-> fill_strand_waiting_i)
		else $error("Fill for a strand that was not waiting for one");

endmodule

`default_nettype wire
